// ==== Makefile ====
# Verilator lint and simulation of the FIR filter block

TOP := tb_fir_filter

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f logic/*.sv logic/*.svh tests/*.sv
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+logic
logic/fir_pkg.sv
logic/fir_settings_regs.sv
logic/fir_sequencer.sv
logic/tap_counter.sv
logic/sample_delay_line.sv
logic/complex_mac.sv
logic/round_and_clip.sv
logic/fir_filter_block.sv
tests/tb_fir_filter.sv

// ==== logic/complex_mac.sv ====
/*
 * Complex MAC: one signed accumulator per rail, tap sample times
 * a real coefficient
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module complex_mac import fir_pkg::*; (
  input  logic                            ce_clk,
  input  logic                            i_reset,
  input  logic                            i_clear_acc,
  input  logic                            i_acc_en,
  input  sample_u                         i_tap_sample,
  input  logic signed [`FIR_SAMPLE_W-1:0] i_coef,
  output logic signed [`FIR_ACC_W-1:0]    o_acc_i,
  output logic signed [`FIR_ACC_W-1:0]    o_acc_q
);

  logic signed [`FIR_ACC_W-1:0] prod_i;
  logic signed [`FIR_ACC_W-1:0] prod_q;
  logic first_tap;

  // Products sign-extended to the accumulator width
  assign prod_i = i_tap_sample.iq.i * i_coef;
  assign prod_q = i_tap_sample.iq.q * i_coef;

  // Set by a clear, consumed by the next accumulate
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      first_tap <= 1'b0;
    end else if (i_clear_acc) begin
      first_tap <= 1'b1;
    end else if (i_acc_en) begin
      first_tap <= 1'b0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_acc_en) begin
      if (first_tap) begin
        o_acc_i <= prod_i;
        o_acc_q <= prod_q;
      end else begin
        o_acc_i <= o_acc_i + prod_i;
        o_acc_q <= o_acc_q + prod_q;
      end
    end
  end

endmodule

// ==== logic/fir_filter_block.sv ====
/*
 * FIR filter block for complex 16-bit I/Q samples with settings bus
 * coefficient reload, bypass and readback
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module fir_filter_block import fir_pkg::*; (
  input  logic        ce_clk,
  input  logic        i_reset,
  input  logic        i_clear,
  // Settings bus
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  // Readback
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data,
  // Sample input stream
  input  logic [31:0] i_tdata,
  input  logic        i_tlast,
  input  logic        i_tvalid,
  output logic        o_tready,
  // Sample output stream
  output logic [31:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready
);

  logic [$clog2(`FIR_NUM_TAPS)-1:0] tap_index;
  logic signed [`FIR_SAMPLE_W-1:0]  coef;
  logic signed [`FIR_ACC_W-1:0]     acc_i;
  logic signed [`FIR_ACC_W-1:0]     acc_q;
  sample_u tap_sample;
  sample_u newest;
  logic bypass, idle, shift, tap_start, tap_advance, tap_last;
  logic acc_clear, acc_en, round_load;

  ////////////////////
  // Control
  ////////////////////
  fir_settings_regs settings0 (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_idle(idle), .i_tap_index(tap_index), .o_coef(coef), .o_bypass(bypass),
    .i_rb_addr(i_rb_addr), .o_rb_data(o_rb_data));

  fir_sequencer seq0 (
    .ce_clk(ce_clk), .i_reset(i_reset),
    .i_tvalid(i_tvalid), .i_tlast(i_tlast), .o_tready(o_tready),
    .i_out_ready(i_tready), .o_out_valid(o_tvalid), .o_out_last(o_tlast),
    .i_bypass(bypass), .i_tap_last(tap_last),
    .o_shift(shift), .o_tap_start(tap_start), .o_tap_advance(tap_advance),
    .o_acc_clear(acc_clear), .o_acc_en(acc_en), .o_round_load(round_load),
    .o_idle(idle));

  tap_counter taps0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_start(tap_start),
    .i_advance(tap_advance), .o_index(tap_index), .o_last(tap_last));

  ////////////////////
  // Datapath
  ////////////////////
  sample_delay_line delay0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_clear(i_clear), .i_shift(shift),
    .i_sample(i_tdata), .i_tap_index(tap_index),
    .o_tap_sample(tap_sample), .o_newest(newest));

  complex_mac mac0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_clear_acc(acc_clear),
    .i_acc_en(acc_en), .i_tap_sample(tap_sample), .i_coef(coef),
    .o_acc_i(acc_i), .o_acc_q(acc_q));

  round_and_clip round0 (
    .ce_clk(ce_clk), .i_reset(i_reset), .i_load(round_load),
    .i_bypass(bypass), .i_acc_i(acc_i), .i_acc_q(acc_q),
    .i_raw(newest), .o_tdata(o_tdata));

endmodule

// ==== logic/fir_macros.svh ====
/*
 * FIR filter block constants: tap count, widths and settings addresses
 */
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// Filter geometry
`define FIR_NUM_TAPS 8
`define FIR_SAMPLE_W 16
// 16x16 product plus growth over eight taps
`define FIR_ACC_W 35

// Settings bus register map
`define FIR_SR_RELOAD      8'd128
`define FIR_SR_RELOAD_LAST 8'd129
`define FIR_SR_CONFIG      8'd130

// Readback map
`define FIR_RB_NUM_TAPS 8'd0
`define FIR_RB_DEFAULT  64'h0BADC0DE0BADC0DE

`endif

// ==== logic/fir_pkg.sv ====
/*
 * FIR filter block types: sample and settings word views, sequencer states
 */
`include "fir_macros.svh"

package fir_pkg;

  // I in the upper half, Q in the lower half
  typedef struct packed {
    logic signed [`FIR_SAMPLE_W-1:0] i;
    logic signed [`FIR_SAMPLE_W-1:0] q;
  } iq_t;

  typedef union packed {
    logic [2*`FIR_SAMPLE_W-1:0] raw;
    iq_t                        iq;
  } sample_u;

  // Reload writes carry a Q1.15 coefficient in the low half
  typedef struct packed {
    logic [15:0]        pad;
    logic signed [15:0] value;
  } coef_view_t;

  typedef struct packed {
    logic [30:0] rsvd;
    logic        bypass;
  } cfg_view_t;

  typedef union packed {
    coef_view_t coef;
    cfg_view_t  cfg;
  } set_word_u;

  typedef enum logic [1:0] {IDLE, MAC, ROUND, OUT} fir_state_e;

endpackage

// ==== logic/fir_sequencer.sv ====
/*
 * FIR sequencer: accepts one sample, runs the tap MAC pass, loads the
 * rounder and holds the result until the output handshake
 */
`timescale 1ns/1ns

module fir_sequencer import fir_pkg::*; (
  input  logic ce_clk,
  input  logic i_reset,
  // Input stream handshake
  input  logic i_tvalid,
  input  logic i_tlast,
  output logic o_tready,
  // Output stream handshake
  input  logic i_out_ready,
  output logic o_out_valid,
  output logic o_out_last,
  input  logic i_bypass,
  input  logic i_tap_last,
  // Datapath strobes
  output logic o_shift,
  output logic o_tap_start,
  output logic o_tap_advance,
  output logic o_acc_clear,
  output logic o_acc_en,
  output logic o_round_load,
  output logic o_idle
);

  fir_state_e state;
  fir_state_e next_state;
  logic accept;

  assign accept = i_tvalid && o_tready;
  assign o_idle = (state == IDLE);

  always_comb begin
    next_state    = state;
    o_shift       = 1'b0;
    o_tap_start   = 1'b0;
    o_tap_advance = 1'b0;
    o_acc_clear   = 1'b0;
    o_acc_en      = 1'b0;
    o_round_load  = 1'b0;
    case (state)
      IDLE: begin
        if (accept) begin
          o_shift = 1'b1;
          if (i_bypass) begin
            // Newest word goes straight to the rounder's raw path
            next_state = ROUND;
          end else begin
            o_tap_start = 1'b1;
            o_acc_clear = 1'b1;
            next_state  = MAC;
          end
        end
      end
      MAC: begin
        o_acc_en = 1'b1;
        if (i_tap_last) begin
          next_state = ROUND;
        end else begin
          o_tap_advance = 1'b1;
        end
      end
      ROUND: begin
        o_round_load = 1'b1;
        next_state   = OUT;
      end
      OUT: begin
        if (i_out_ready) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  ////////////////////
  // State and handshake flags
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      state       <= IDLE;
      o_tready    <= 1'b0;
      o_out_valid <= 1'b0;
      o_out_last  <= 1'b0;
    end else begin
      state       <= next_state;
      // Ready exactly while the state is IDLE
      o_tready    <= (next_state == IDLE);
      o_out_valid <= (next_state == OUT);
      if (accept) begin
        o_out_last <= i_tlast;
      end
    end
  end

endmodule

// ==== logic/fir_settings_regs.sv ====
/*
 * FIR settings registers: coefficient reload into a shadow bank, commit
 * into the active bank when the filter is idle, config and readback
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module fir_settings_regs import fir_pkg::*; (
  input  logic                                  ce_clk,
  input  logic                                  i_reset,
  input  logic                                  i_set_stb,
  input  logic [7:0]                            i_set_addr,
  input  logic [31:0]                           i_set_data,
  input  logic                                  i_idle,
  input  logic [$clog2(`FIR_NUM_TAPS)-1:0]      i_tap_index,
  output logic signed [`FIR_SAMPLE_W-1:0]       o_coef,
  output logic                                  o_bypass,
  input  logic [7:0]                            i_rb_addr,
  output logic [63:0]                           o_rb_data
);

  set_word_u set_word;
  logic signed [`FIR_SAMPLE_W-1:0] shadow_bank [`FIR_NUM_TAPS];
  logic signed [`FIR_SAMPLE_W-1:0] active_bank [`FIR_NUM_TAPS];
  logic [$clog2(`FIR_NUM_TAPS)-1:0] wr_ptr;
  logic commit_pending;
  logic reload_wr;
  logic swap;

  assign set_word  = i_set_data;
  assign reload_wr = i_set_stb &&
                     (i_set_addr == `FIR_SR_RELOAD || i_set_addr == `FIR_SR_RELOAD_LAST);
  // Swap only while idle since the MAC reads the active bank
  assign swap      = commit_pending && i_idle;

  ////////////////////
  // Coefficient banks
  ////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        shadow_bank[k] <= '0;
        active_bank[k] <= '0;
      end
      wr_ptr         <= '0;
      commit_pending <= 1'b0;
    end else begin
      if (reload_wr) begin
        shadow_bank[wr_ptr] <= set_word.coef.value;
        wr_ptr              <= wr_ptr + 1'b1;
      end
      if (i_set_stb && i_set_addr == `FIR_SR_RELOAD_LAST) begin
        commit_pending <= 1'b1;
      end else if (swap) begin
        commit_pending <= 1'b0;
      end
      if (swap) begin
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
          active_bank[k] <= shadow_bank[k];
        end
        wr_ptr <= '0;
      end
    end
  end

  assign o_coef = active_bank[i_tap_index];

  // Config register
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_bypass <= 1'b0;
    end else if (i_set_stb && i_set_addr == `FIR_SR_CONFIG) begin
      o_bypass <= set_word.cfg.bypass;
    end
  end

  ////////////////////
  // Readback
  ////////////////////
  always_comb begin
    case (i_rb_addr)
      `FIR_RB_NUM_TAPS: o_rb_data = 64'(`FIR_NUM_TAPS);
      default:          o_rb_data = `FIR_RB_DEFAULT;
    endcase
  end

endmodule

// ==== logic/round_and_clip.sv ====
/*
 * Output stage: round both accumulators by 15 bits and saturate to
 * 16 bits, or pass the raw word through in bypass
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module round_and_clip import fir_pkg::*; (
  input  logic                         ce_clk,
  input  logic                         i_reset,
  input  logic                         i_load,
  input  logic                         i_bypass,
  input  logic signed [`FIR_ACC_W-1:0] i_acc_i,
  input  logic signed [`FIR_ACC_W-1:0] i_acc_q,
  input  sample_u                      i_raw,
  output sample_u                      o_tdata
);

  // Round half up, drop 15 fraction bits, clip to the 16-bit range
  function automatic logic signed [`FIR_SAMPLE_W-1:0] round_clip(
    input logic signed [`FIR_ACC_W-1:0] acc
  );
    logic signed [`FIR_ACC_W-1:0]  biased;
    logic signed [`FIR_ACC_W-16:0] shifted;
    biased  = acc + `FIR_ACC_W'(1 << 14);
    shifted = biased[`FIR_ACC_W-1:15];
    if (shifted > 32767) begin
      return 16'sh7fff;
    end else if (shifted < -32768) begin
      return 16'sh8000;
    end
    return shifted[`FIR_SAMPLE_W-1:0];
  endfunction

  // Held while the sequencer waits for the output handshake
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_tdata <= '0;
    end else if (i_load) begin
      if (i_bypass) begin
        o_tdata.raw <= i_raw.raw;
      end else begin
        o_tdata.iq.i <= round_clip(i_acc_i);
        o_tdata.iq.q <= round_clip(i_acc_q);
      end
    end
  end

endmodule

// ==== logic/sample_delay_line.sv ====
/*
 * Sample history of the last NUM_TAPS words, newest at index 0
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module sample_delay_line import fir_pkg::*; (
  input  logic                             ce_clk,
  input  logic                             i_reset,
  input  logic                             i_clear,
  input  logic                             i_shift,
  input  sample_u                          i_sample,
  input  logic [$clog2(`FIR_NUM_TAPS)-1:0] i_tap_index,
  output sample_u                          o_tap_sample,
  output sample_u                          o_newest
);

  sample_u history [`FIR_NUM_TAPS];

  always_ff @(posedge ce_clk) begin
    if (i_reset || i_clear) begin
      // Filter restarts from an all-zero history
      for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        history[k] <= '0;
      end
    end else if (i_shift) begin
      history[0] <= i_sample;
      for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
        history[k] <= history[k-1];
      end
    end
  end

  // Tap read for the MAC
  assign o_tap_sample = history[i_tap_index];

  // Bypass path takes the word just shifted in
  assign o_newest = history[0];

endmodule

// ==== logic/tap_counter.sv ====
/*
 * Tap index counter for the MAC pass, flags the last tap
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module tap_counter (
  input  logic                             ce_clk,
  input  logic                             i_reset,
  input  logic                             i_start,
  input  logic                             i_advance,
  output logic [$clog2(`FIR_NUM_TAPS)-1:0] o_index,
  output logic                             o_last
);

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_index <= '0;
    end else if (i_start) begin
      o_index <= '0;
    end else if (i_advance) begin
      o_index <= o_index + 1'b1;
    end
  end

  assign o_last = (o_index == ($clog2(`FIR_NUM_TAPS))'(`FIR_NUM_TAPS - 1));

endmodule

// ==== tests/tb_fir_filter.sv ====
/*
 * FIR filter block testbench: readback, impulse, saturation,
 * back-pressure, coefficient swap, clear and bypass
 */
`timescale 1ns/1ns
`include "fir_macros.svh"

module tb_fir_filter;

  logic        ce_clk, i_reset, i_clear, i_set_stb;
  logic [7:0]  i_set_addr, i_rb_addr;
  logic [31:0] i_set_data, i_tdata, o_tdata;
  logic [63:0] o_rb_data;
  logic        i_tlast, i_tvalid, o_tready, o_tlast, o_tvalid, i_tready;

  integer seed = 32'h6fcb_da1c;
  int errors, checks, tests_run, tests_failed, test_errors;
  string cur_test;
  logic stall_en, bypass_on, stalled;
  logic [32:0] held_word;
  logic [32:0] expected_q[$];
  logic signed [15:0] ref_coef [`FIR_NUM_TAPS];
  logic signed [15:0] new_coef [`FIR_NUM_TAPS];
  logic [31:0] ref_hist [`FIR_NUM_TAPS];

  fir_filter_block dut0 (.*);

  always #5 ce_clk = ~ce_clk;

  // Random output stalls when enabled
  always @(posedge ce_clk) begin
    #1;
    i_tready = stall_en ? 1'($random(seed)) : 1'b1;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("Timeout in test %s: %s", cur_test, what);
    finish_run();
  endtask

  ////////////////////
  // Reference filter
  ////////////////////
  function automatic logic [15:0] saturate(input longint acc);
    longint scaled;
    scaled = (acc + 64'sd16384) >>> 15;
    if (scaled > 32767) begin
      return 16'h7fff;
    end else if (scaled < -32768) begin
      return 16'h8000;
    end
    return scaled[15:0];
  endfunction

  // History shifts in bypass too
  function automatic logic [31:0] filter_ref(input logic [31:0] word);
    longint acc_i;
    longint acc_q;
    for (int k = `FIR_NUM_TAPS - 1; k > 0; k--) begin
      ref_hist[k] = ref_hist[k-1];
    end
    ref_hist[0] = word;
    if (bypass_on) begin
      return word;
    end
    acc_i = 0;
    acc_q = 0;
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      acc_i += longint'($signed(ref_hist[k][31:16])) * ref_coef[k];
      acc_q += longint'($signed(ref_hist[k][15:0])) * ref_coef[k];
    end
    return {saturate(acc_i), saturate(acc_q)};
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge ce_clk);
    #1;
    i_set_stb = 1'b0;
  endtask

  task automatic stage_coefs();
    for (int k = 0; k < `FIR_NUM_TAPS - 1; k++) begin
      write_setting(`FIR_SR_RELOAD, {16'h0, new_coef[k]});
    end
  endtask

  task automatic commit_coefs();
    write_setting(`FIR_SR_RELOAD_LAST, {16'h0, new_coef[`FIR_NUM_TAPS-1]});
    // Swap lands before any later accept
    ref_coef = new_coef;
  endtask

  task automatic load_coefs();
    stage_coefs();
    commit_coefs();
  endtask

  task automatic random_coefs(input int limit);
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      new_coef[k] = 16'($random(seed) % limit);
    end
  endtask

  task automatic send_sample(input logic [31:0] word, input logic last);
    int n;
    n = 0;
    while (o_tready !== 1'b1 && n < 200) begin
      @(posedge ce_clk);
      #1;
      n++;
    end
    if (o_tready !== 1'b1) begin
      timeout_fail("input stream never became ready");
    end else begin
      i_tdata = word;
      i_tlast = last;
      i_tvalid = 1'b1;
      expected_q.push_back({last, filter_ref(word)});
      // Ready was already high, so this edge takes the word
      @(posedge ce_clk);
      #1;
      i_tvalid = 1'b0;
    end
  endtask

  task automatic send_random(input int count);
    logic [31:0] word;
    for (int k = 0; k < count; k++) begin
      word = $random(seed);
      send_sample(word, 1'($random(seed)));
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((expected_q.size() != 0 || o_tready !== 1'b1) && n < 200) begin
      @(posedge ce_clk);
      #1;
      n++;
    end
    if (n >= 200) begin
      timeout_fail("output stream did not drain");
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    wait_drain();
    tests_run++;
    if (errors == test_errors) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s: %0d errors", cur_test, errors - test_errors);
    end
  endtask

  // Output checks at mid-cycle where everything is settled
  always @(negedge ce_clk) begin
    if (!i_reset && o_tvalid) begin
      if (stalled) begin
        check_value($sformatf("%s hold", cur_test), held_word, {o_tlast, o_tdata});
      end
      if (i_tready) begin
        stalled = 1'b0;
        if (expected_q.size() == 0) begin
          errors++;
          $display("Unexpected extra output word %h in test %s", o_tdata, cur_test);
        end else begin
          check_value(cur_test, expected_q.pop_front(), {o_tlast, o_tdata});
        end
      end else begin
        stalled = 1'b1;
        held_word = {o_tlast, o_tdata};
      end
    end
  end

  initial begin
    ce_clk = 1'b0;
    i_reset = 1'b1;
    i_clear = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr = '0;
    i_tdata = '0;
    i_tlast = 1'b0;
    i_tvalid = 1'b0;
    i_tready = 1'b1;
    stall_en = 1'b0;
    bypass_on = 1'b0;
    stalled = 1'b0;
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      ref_hist[k] = '0;
      ref_coef[k] = '0;
    end
    repeat (5) @(posedge ce_clk);
    #1;
    i_reset = 1'b0;

    begin_test("readback");
    i_rb_addr = 8'd0;
    #1;
    check_value("readback tap count", 64'd8, o_rb_data);
    i_rb_addr = 8'd5;
    #1;
    check_value("readback addr 5", 64'h0BADC0DE_0BADC0DE, o_rb_data);
    i_rb_addr = 8'd200;
    #1;
    check_value("readback addr 200", 64'h0BADC0DE_0BADC0DE, o_rb_data);
    end_test();

    begin_test("impulse");
    new_coef = '{16'sd1000, -16'sd2000, 16'sd4096, 16'sd8192,
                 -16'sd16384, 16'sd32767, 16'sh8000, 16'sd300};
    load_coefs();
    send_sample(32'h4000_c000, 1'b0);
    for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
      send_sample(32'h0, k == 3);
    end
    end_test();

    begin_test("saturation");
    random_coefs(32768);
    load_coefs();
    send_random(40);
    end_test();

    begin_test("back-pressure");
    random_coefs(8000);
    load_coefs();
    stall_en = 1'b1;
    send_random(40);
    wait_drain();
    stall_en = 1'b0;
    end_test();

    begin_test("coef swap and clear");
    random_coefs(12000);
    load_coefs();
    send_random(5);
    random_coefs(12000);
    stage_coefs();
    send_random(1);
    // Commit lands on the first MAC edge of the last old-set sample
    commit_coefs();
    send_random(6);
    wait_drain();
    i_clear = 1'b1;
    @(posedge ce_clk);
    #1;
    i_clear = 1'b0;
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      ref_hist[k] = '0;
    end
    send_random(6);
    end_test();

    begin_test("bypass");
    write_setting(`FIR_SR_CONFIG, 32'h1);
    bypass_on = 1'b1;
    send_random(10);
    wait_drain();
    write_setting(`FIR_SR_CONFIG, 32'h0);
    bypass_on = 1'b0;
    send_random(10);
    end_test();

    finish_run();
  end

endmodule
